// ==== filelist.f ====
src/soc_pkg.sv
src/wb_decoder.sv
src/wb_bram.sv
src/csr_bridge.sv
src/sysctl.sv
src/soc_top.sv
sim/tb_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# Exit status is nonzero when the simulation ends in $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_soc -o tb_soc_sim &&
./obj_dir/tb_soc_sim || exit 1

// ==== sim/tb_soc.sv ====
// --------------------------------------------------
// Directed testbench for the bus subsystem
// Bus tasks, RAM, unmapped, GPIO and timer tests
// --------------------------------------------------
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

	// Tests take under 1500 cycles, limit leaves wide margin
	localparam int CYCLE_LIMIT = 4000;
	localparam int RAM_WORDS   = 32;

	logic                  sys_clk;
	logic                  sys_rst;
	wb_req_t               bus_req;
	wb_rsp_t               bus_rsp;
	logic [GPIO_IN_W-1:0]  gpio_in;
	logic [GPIO_OUT_W-1:0] gpio_out;
	logic                  timer_irq;
	int                    cycle_cnt;
	logic [31:0]           lcg_state;
	logic [31:0]           model_mem [1024];
	logic [9:0]            word_list [RAM_WORDS];

	soc_top UUT (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.bus_req_i   (bus_req),
		.bus_rsp_o   (bus_rsp),
		.gpio_i      (gpio_in),
		.gpio_o      (gpio_out),
		.timer_irq_o (timer_irq)
	);

	// --------------------------------------------------
	// Clock, cycle count and timeout
	// --------------------------------------------------
	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	initial cycle_cnt = 0;
	always @(posedge sys_clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("sim failed");
		$fatal(1, "timeout");
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Region 100, address bits 15..2 carry {bank, index}
	function automatic logic [31:0] csr_addr(input logic [3:0] bank, input logic [9:0] idx);
		return {3'b100, 13'd0, bank, idx, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: actual 0x%h expected 0x%h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "check failed");
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "test aborted");
	endtask

	// Starts at a falling edge, counts edges until ack, holds stb through the ack edge
	task automatic bus_cycle(input logic [31:0] adr, input logic we, input logic [31:0] dat,
			input logic [3:0] sel, output logic [31:0] rdat, output int lat);
		lat         = 0;
		bus_req.adr = adr;
		bus_req.dat = dat;
		bus_req.sel = sel;
		bus_req.we  = we;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		do begin
			@(negedge sys_clk);
			lat++;
		end while (!bus_rsp.ack);
		rdat = bus_rsp.dat;
		@(negedge sys_clk);
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		bus_req.we  = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output int lat);
		logic [31:0] unused_dat;
		bus_cycle(adr, 1'b1, dat, sel, unused_dat, lat);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat, output int lat);
		bus_cycle(adr, 1'b0, 32'd0, 4'hF, rdat, lat);
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic test_reset();
		check_value("bus_rsp_o.ack", 32'(bus_rsp.ack), 32'd0);
		check_value("gpio_o", 32'(gpio_out), 32'd0);
		check_value("timer_irq_o", 32'(timer_irq), 32'd0);
	endtask

	task automatic test_ram();
		logic [31:0] dat;
		logic [31:0] rnd;
		logic [3:0]  sel;
		int          lat;
		// Full-word init of the chosen words
		for (int i = 0; i < RAM_WORDS; i++) begin
			rnd          = next_rand();
			word_list[i] = rnd[25:16];
			dat          = next_rand();
			model_mem[word_list[i]] = dat;
			bus_write({20'd0, word_list[i], 2'b00}, dat, 4'hF, lat);
		end
		// Partial writes merged into the model by byte
		for (int i = 0; i < RAM_WORDS; i++) begin
			rnd = next_rand();
			sel = rnd[19:16];
			dat = next_rand();
			for (int b = 0; b < 4; b++)
				if (sel[b])
					model_mem[word_list[i]][8*b +: 8] = dat[8*b +: 8];
			bus_write({20'd0, word_list[i], 2'b00}, dat, sel, lat);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			bus_read({20'd0, word_list[i], 2'b00}, dat, lat);
			check_value("ram read data", dat, model_mem[word_list[i]]);
			if (i == 0)
				check_value("ram ack latency", 32'(lat), 32'd1);
		end
	endtask

	task automatic test_unmapped();
		logic [31:0] dat;
		int          lat;
		bus_read({3'b010, 17'd0, word_list[0], 2'b00}, dat, lat);
		check_value("unmapped read data", dat, 32'd0);
		check_value("unmapped ack latency", 32'(lat), 32'd1);
		// Same word offset as a RAM word, must not alias
		bus_write({3'b010, 17'd0, word_list[0], 2'b00}, ~model_mem[word_list[0]], 4'hF, lat);
		bus_read({20'd0, word_list[0], 2'b00}, dat, lat);
		check_value("ram after unmapped write", dat, model_mem[word_list[0]]);
	endtask

	task automatic test_sysctl();
		logic [31:0] dat;
		int          lat;
		bus_read(csr_addr(SYSCTL_BANK, REG_SYSTEM_ID), dat, lat);
		check_value("system id", dat, SYSTEM_ID);
		check_value("csr ack latency", 32'(lat), 32'd2);
		bus_write(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h0000_000A, 4'hF, lat);
		check_value("gpio_o", 32'(gpio_out), 32'h0000_000A);
		bus_read(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), dat, lat);
		check_value("gpio out readback", dat, 32'h0000_000A);
		gpio_in = 3'b101;
		repeat (2) @(negedge sys_clk);
		bus_read(csr_addr(SYSCTL_BANK, REG_GPIO_IN), dat, lat);
		check_value("gpio in", dat, 32'h0000_0005);
		bus_read(csr_addr(4'd2, REG_SYSTEM_ID), dat, lat);
		check_value("unused bank read", dat, 32'd0);
	endtask

	task automatic test_timer();
		logic [31:0] dat;
		int          lat;
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_CMP), 32'd20, 4'hF, lat);
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), 32'd1, 4'hF, lat);
		for (int i = 0; i < 30 && !timer_irq; i++)
			@(negedge sys_clk);
		if (!timer_irq)
			abort_run("timer interrupt never came within 30 cycles");
		bus_read(csr_addr(SYSCTL_BANK, REG_IRQ_STATUS), dat, lat);
		check_value("irq status", dat, 32'd1);
		// One-shot mode, enable bit must be gone
		bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), dat, lat);
		check_value("timer ctrl after one-shot", dat, 32'd0);
		bus_write(csr_addr(SYSCTL_BANK, REG_IRQ_STATUS), 32'd1, 4'hF, lat);
		check_value("timer_irq_o after clear", 32'(timer_irq), 32'd0);
	endtask

	task automatic test_autoreload();
		logic [31:0] dat;
		int          lat;
		int          fires;
		int          start;
		fires = 0;
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_CMP), 32'd15, 4'hF, lat);
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), 32'd3, 4'hF, lat);
		start = cycle_cnt;
		while (cycle_cnt - start < 80 && fires < 3) begin
			@(negedge sys_clk);
			if (timer_irq) begin
				fires++;
				bus_write(csr_addr(SYSCTL_BANK, REG_IRQ_STATUS), 32'd1, 4'hF, lat);
			end
		end
		if (fires < 3)
			abort_run("auto-reload timer fired fewer than three times in 80 cycles");
		bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), dat, lat);
		check_value("timer ctrl after auto-reload", dat, 32'd3);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		lcg_state = 32'd68;
		sys_rst   = 1'b0;
		bus_req   = '0;
		gpio_in   = '0;
		repeat (5) @(negedge sys_clk);
		sys_rst = 1'b1;
		@(negedge sys_clk);
		test_reset();
		test_ram();
		test_unmapped();
		test_sysctl();
		test_timer();
		test_autoreload();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== src/csr_bridge.sv ====
// --------------------------------------------------
// Bus to CSR bridge
// One CSR access per bus cycle
// Ack two clocks after the request
// --------------------------------------------------
`timescale 1ns/1ps

module csr_bridge import soc_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  wb_req_t     req_i,
	output wb_rsp_t     rsp_o,
	output csr_req_t    csr_o,
	input  logic [31:0] csr_di_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_ACK
	} state_t;

	state_t      state;
	logic [31:0] rd_dat;

	// Address and data follow the held request
	// Write strobe only for the access cycle
	assign csr_o.a  = req_i.adr[15:2];
	assign csr_o.dw = req_i.dat;
	assign csr_o.we = (state == ST_ACCESS) & req_i.we;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (req_i.cyc && req_i.stb) state <= ST_ACCESS;
				ST_ACCESS: state <= ST_ACK;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Read word is ready from sysctl by the end of the access cycle
	always_ff @(posedge sys_clk) begin
		if (state == ST_ACCESS)
			rd_dat <= csr_di_i;
	end

	assign rsp_o.dat = rd_dat;
	assign rsp_o.ack = (state == ST_ACK);

	// Write enable only inside a held bus write
	a_we_access: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		csr_o.we |-> req_i.cyc && req_i.stb &&
			$stable(req_i.adr) && $stable(req_i.dat));

endmodule

// ==== src/soc_pkg.sv ====
// --------------------------------------------------
// Shared bus types, address map and CSR layout
// for the bus subsystem
// --------------------------------------------------

package soc_pkg;

	// --------------------------------------------------
	// Bus types
	// --------------------------------------------------

	// Master to slave request
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	// Slave to master response
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// CSR access, word address is {bank, index}
	typedef struct packed {
		logic [13:0] a;
		logic        we;
		logic [31:0] dw;
	} csr_req_t;

	// --------------------------------------------------
	// Address map
	// --------------------------------------------------

	// Region is taken from address bits 31..29
	localparam logic [2:0] REGION_BRAM = 3'b000;
	localparam logic [2:0] REGION_CSR  = 3'b100;

	// 1024 words of block RAM
	localparam int BRAM_ADR_W = 10;

	// System controller bank and registers
	localparam logic [3:0] SYSCTL_BANK    = 4'd1;
	localparam logic [9:0] REG_GPIO_IN    = 10'd0;
	localparam logic [9:0] REG_GPIO_OUT   = 10'd1;
	localparam logic [9:0] REG_TIMER_CTRL = 10'd2;
	localparam logic [9:0] REG_TIMER_CMP  = 10'd3;
	localparam logic [9:0] REG_TIMER_CNT  = 10'd4;
	localparam logic [9:0] REG_IRQ_STATUS = 10'd5;
	localparam logic [9:0] REG_SYSTEM_ID  = 10'd6;

	// Timer control bits
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_AR_BIT = 1;

	localparam int GPIO_IN_W  = 3;
	localparam int GPIO_OUT_W = 4;

	// "SOC1" in ASCII
	localparam logic [31:0] SYSTEM_ID = 32'h534F_4331;

endpackage

// ==== src/soc_top.sv ====
// --------------------------------------------------
// Bus subsystem top level
// Decoder, block RAM, CSR bridge, system controller
// --------------------------------------------------
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  wb_req_t               bus_req_i,
	output wb_rsp_t               bus_rsp_o,
	input  logic [GPIO_IN_W-1:0]  gpio_i,
	output logic [GPIO_OUT_W-1:0] gpio_o,
	output logic                  timer_irq_o
);

	// Slave side of the decoder
	wb_req_t     ram_req;
	wb_rsp_t     ram_rsp;
	wb_req_t     brg_req;
	wb_rsp_t     brg_rsp;

	// CSR bus
	csr_req_t    csr_bus;
	logic [31:0] csr_rd;

	wb_decoder u_dec (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.m_req_i   (bus_req_i),
		.m_rsp_o   (bus_rsp_o),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp),
		.csr_req_o (brg_req),
		.csr_rsp_i (brg_rsp)
	);

	wb_bram u_bram (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	csr_bridge u_brg (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.req_i    (brg_req),
		.rsp_o    (brg_rsp),
		.csr_o    (csr_bus),
		.csr_di_i (csr_rd)
	);

	// Only CSR slave, so no read-data OR tree
	sysctl u_sysctl (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.csr_i       (csr_bus),
		.csr_do_o    (csr_rd),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.timer_irq_o (timer_irq_o)
	);

endmodule

// ==== src/sysctl.sv ====
// --------------------------------------------------
// System controller on the CSR bus
// GPIO, one timer with irq, system identifier
// --------------------------------------------------
`timescale 1ns/1ps

module sysctl import soc_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  csr_req_t              csr_i,
	output logic [31:0]           csr_do_o,
	input  logic [GPIO_IN_W-1:0]  gpio_i,
	output logic [GPIO_OUT_W-1:0] gpio_o,
	output logic                  timer_irq_o
);

	logic [3:0]            bank;
	logic [9:0]            idx;
	logic                  bank_hit;
	logic                  wr;
	logic [GPIO_IN_W-1:0]  gpio_s1;
	logic [GPIO_IN_W-1:0]  gpio_s2;
	logic [GPIO_OUT_W-1:0] gpio_out;
	logic [1:0]            timer_ctrl;
	logic [31:0]           timer_cmp;
	logic [31:0]           timer_cnt;
	logic                  irq_pend;

	assign bank     = csr_i.a[13:10];
	assign idx      = csr_i.a[9:0];
	assign bank_hit = (bank == SYSCTL_BANK);
	assign wr       = csr_i.we & bank_hit;

	// --------------------------------------------------
	// GPIO input synchronizer
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_s1 <= gpio_i;
		gpio_s2 <= gpio_s1;
	end

	// --------------------------------------------------
	// Control registers and timer
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!sys_rst) begin
			gpio_out   <= '0;
			timer_ctrl <= '0;
			timer_cmp  <= '0;
			timer_cnt  <= '0;
			irq_pend   <= 1'b0;
		end else begin
			// Write one to clear
			if (wr && idx == REG_IRQ_STATUS && csr_i.dw[0])
				irq_pend <= 1'b0;
			if (timer_ctrl[CTRL_EN_BIT]) begin
				if (timer_cnt == timer_cmp) begin
					timer_cnt <= '0;
					irq_pend  <= 1'b1;
					// One-shot stops on match
					if (!timer_ctrl[CTRL_AR_BIT])
						timer_ctrl[CTRL_EN_BIT] <= 1'b0;
				end else begin
					timer_cnt <= timer_cnt + 32'd1;
				end
			end
			// Bus writes win over the timer
			if (wr) begin
				case (idx)
					REG_GPIO_OUT:   gpio_out   <= csr_i.dw[GPIO_OUT_W-1:0];
					REG_TIMER_CTRL: timer_ctrl <= csr_i.dw[1:0];
					REG_TIMER_CMP:  timer_cmp  <= csr_i.dw;
					REG_TIMER_CNT:  timer_cnt  <= csr_i.dw;
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// Read port
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		csr_do_o <= '0;
		if (bank_hit) begin
			case (idx)
				REG_GPIO_IN:    csr_do_o <= {{(32-GPIO_IN_W){1'b0}}, gpio_s2};
				REG_GPIO_OUT:   csr_do_o <= {{(32-GPIO_OUT_W){1'b0}}, gpio_out};
				REG_TIMER_CTRL: csr_do_o <= {30'd0, timer_ctrl};
				REG_TIMER_CMP:  csr_do_o <= timer_cmp;
				REG_TIMER_CNT:  csr_do_o <= timer_cnt;
				REG_IRQ_STATUS: csr_do_o <= {31'd0, irq_pend};
				REG_SYSTEM_ID:  csr_do_o <= SYSTEM_ID;
				default:        csr_do_o <= '0;
			endcase
		end
	end

	assign gpio_o      = gpio_out;
	assign timer_irq_o = irq_pend;

endmodule

// ==== src/wb_bram.sv ====
// --------------------------------------------------
// Block RAM slave, 32-bit words with byte enables
// --------------------------------------------------
`timescale 1ns/1ps

module wb_bram import soc_pkg::*; (
	input  logic    sys_clk,
	input  logic    sys_rst,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [31:0]           mem [2**BRAM_ADR_W];
	logic [BRAM_ADR_W-1:0] word_adr;
	logic [31:0]           rd_dat;
	logic                  ack;
	logic                  wr_en;

	// Drop the byte offset
	assign word_adr = req_i.adr[BRAM_ADR_W+1:2];
	assign wr_en    = req_i.cyc & req_i.stb & req_i.we & ~ack;

	// Storage and read port
	always_ff @(posedge sys_clk) begin
		for (int b = 0; b < 4; b++) begin
			if (wr_en && req_i.sel[b])
				mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
		end
		rd_dat <= mem[word_adr];
	end

	// Single ack per access, held off while stb stays up
	always_ff @(posedge sys_clk) begin
		if (!sys_rst)
			ack <= 1'b0;
		else
			ack <= req_i.cyc & req_i.stb & ~ack;
	end

	assign rsp_o.dat = rd_dat;
	assign rsp_o.ack = ack;

	a_ack_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		rsp_o.ack |=> !rsp_o.ack);

endmodule

// ==== src/wb_decoder.sv ====
// --------------------------------------------------
// Address decoder for the single bus master
// Unmapped regions get a zero-data ack
// --------------------------------------------------
`timescale 1ns/1ps

module wb_decoder import soc_pkg::*; (
	input  logic    sys_clk,
	input  logic    sys_rst,
	input  wb_req_t m_req_i,
	output wb_rsp_t m_rsp_o,
	output wb_req_t ram_req_o,
	input  wb_rsp_t ram_rsp_i,
	output wb_req_t csr_req_o,
	input  wb_rsp_t csr_rsp_i
);

	logic [2:0] region;
	logic       hit_ram;
	logic       hit_csr;
	logic       unm_ack;

	// Top three address bits pick the slave
	assign region  = m_req_i.adr[31:29];
	assign hit_ram = (region == REGION_BRAM);
	assign hit_csr = (region == REGION_CSR);

	// Same request to both, only the selected one is strobed
	always_comb begin
		ram_req_o     = m_req_i;
		ram_req_o.cyc = m_req_i.cyc & hit_ram;
		ram_req_o.stb = m_req_i.stb & hit_ram;
		csr_req_o     = m_req_i;
		csr_req_o.cyc = m_req_i.cyc & hit_csr;
		csr_req_o.stb = m_req_i.stb & hit_csr;
	end

	// Local one-cycle ack for holes in the map
	always_ff @(posedge sys_clk) begin
		if (!sys_rst)
			unm_ack <= 1'b0;
		else
			unm_ack <= m_req_i.cyc & m_req_i.stb & ~hit_ram & ~hit_csr & ~unm_ack;
	end

	// Response mux follows the held address
	always_comb begin
		if (hit_ram) begin
			m_rsp_o = ram_rsp_i;
		end else if (hit_csr) begin
			m_rsp_o = csr_rsp_i;
		end else begin
			m_rsp_o.dat = '0;
			m_rsp_o.ack = unm_ack;
		end
	end

	a_one_slave: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		!(ram_req_o.stb && csr_req_o.stb));

	// Whichever slave answers, the master must still be strobing
	a_ack_has_stb: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		m_rsp_o.ack |-> m_req_i.stb);

endmodule
